// ==== verilog.f ====
+incdir+.
conv_pkg.sv
mac_if.sv
approx_mult8.sv
conv_row_mac.sv
conv_apb_regs.sv
conv_row_top.sv
tb_clk_gen.sv
tb_conv_row_assert.sv
tb_conv_row.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv *.svh) verilog.f

.PHONY: all run clean

all: run

obj_dir/sim_conv_row: $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module tb_conv_row -o sim_conv_row

run: obj_dir/sim_conv_row
	./obj_dir/sim_conv_row > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_conv_row.sv ====
`include "conv_macros.svh"

module tb_conv_row import conv_pkg::*; ();

    localparam int num_directed = 6;
    localparam int num_rows     = num_directed + 20;
    localparam int reset_cycles = 2;
    // A row needs under 40 cycles. Four extra slots cover reset, readback and error phases.
    localparam int watchdog_cycles = (num_rows + 4) * 40 + reset_cycles;

    // One correction term per word, in hex digits: op (0 single, 1 and, 2 or, 3 xor),
    // row and column of the first bit, row and column of the second bit, two-digit weight.
    localparam logic [27:0] approx_terms [24] = '{
        28'h147560c, 28'h347560b, 28'h037000a, 28'h2273609, 28'h0170008, 28'h3071607,
        28'h1233206, 28'h3041305, 28'h1021103, 28'h0200002, 28'h057000c, 28'h145540a,
        28'h3455409, 28'h2253408, 28'h2051405, 28'h2213003, 28'h146550a, 28'h1263508,
        28'h3223105, 28'h246550a, 28'h2263508, 28'h2435208, 28'h1445308, 28'h2445308
    };

    logic                   clk;
    logic                   arst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`CONV_AW-1:0]    paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    integer                 seed;
    logic                   row_mode [num_rows];
    logic [`CONV_DW-1:0]    row_w    [num_rows][`CONV_TAPS];
    logic [`CONV_DW-1:0]    row_p    [num_rows][`CONV_TAPS];
    logic [`CONV_ACC_W-1:0] row_sum  [num_rows];

    tb_clk_gen #(.period(20)) u_clk_gen (.clk(clk));

    conv_row_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int unsigned exact_ref(input logic [7:0] w, input logic [7:0] p);
        return 32'(w) * 32'(p);
    endfunction

    // Bit (i, j) of the partial products is x[i] & y[j] at weight 2**(i+j).
    function automatic int unsigned approx_ref(input logic [7:0] x, input logic [7:0] y);
        int unsigned s;
        logic [27:0] t;
        logic        a;
        logic        b;
        s = (x[6] ? (32'(y) << 6) : 32'd0) + (x[7] ? (32'(y) << 7) : 32'd0);
        for (int k = 0; k < 24; k++) begin
            t = approx_terms[k];
            a = x[t[22:20]] & y[t[18:16]];
            b = x[t[14:12]] & y[t[10:8]];
            case (t[27:24])
                4'd1: a = a & b;
                4'd2: a = a | b;
                4'd3: a = a ^ b;
                default: ;
            endcase
            if (a) begin
                s = s + (32'd1 << t[7:0]);
            end
        end
        return s & 32'hffff;
    endfunction

    task automatic set_row(input int r, input logic mode, input logic [39:0] w,
                           input logic [39:0] p, input logic [`CONV_ACC_W-1:0] sum);
        row_mode[r] = mode;
        row_sum[r]  = sum;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            row_w[r][t] = w[39 - 8 * t -: 8];
            row_p[r][t] = p[39 - 8 * t -: 8];
        end
    endtask

    task automatic fill_table();
        int unsigned s;
        set_row(0, 1'b1, 40'hff_ff_ff_ff_ff, 40'hff_ff_ff_ff_ff, 19'd325125);
        set_row(1, 1'b1, 40'h01_02_03_04_05, 40'h0a_14_1e_28_32, 19'd550);
        set_row(2, 1'b0, 40'h40_80_c0_00_c0, 40'hff_12_34_56_ff, 19'd77568);
        set_row(3, 1'b0, 40'h00_00_00_00_00, 40'h00_00_00_00_00, 19'd0);
        set_row(4, 1'b0, 40'h3f_11_ff_01_80, 40'h00_00_00_00_00, 19'd0);
        set_row(5, 1'b1, 40'hc8_64_32_19_0c, 40'h03_07_0b_0d_11, 19'd2379);
        for (int r = num_directed; r < num_rows; r++) begin
            s = 0;
            row_mode[r] = 1'($random(seed));
            for (int t = 0; t < `CONV_TAPS; t++) begin
                row_w[r][t] = 8'($random(seed));
                row_p[r][t] = 8'($random(seed));
                s = s + (row_mode[r] ? exact_ref(row_w[r][t], row_p[r][t])
                                     : approx_ref(row_w[r][t], row_p[r][t]));
            end
            row_sum[r] = 19'(s);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and APB transfers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Called on a falling edge; returns on the falling edge after the access cycle.
    task automatic apb_xfer(input logic wr, input logic [`CONV_AW-1:0] addr,
                            input logic [31:0] wdata, input logic exp_err,
                            output logic [31:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        check_value("pready", 32'(pready), 32'h1);
        check_value($sformatf("pslverr at 0x%02h", addr), 32'(pslverr), 32'(exp_err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`CONV_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused_rdata;
        apb_xfer(1'b1, addr, data, exp_err, unused_rdata);
    endtask

    task automatic apb_read(input logic [`CONV_AW-1:0] addr, output logic [31:0] data,
                            input logic exp_err);
        apb_xfer(1'b0, addr, 32'd0, exp_err, data);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (status[1] !== 1'b1) begin
            apb_read(REG_STATUS, status, 1'b0);
        end
    endtask

    task automatic load_row(input int r);
        for (int t = 0; t < `CONV_TAPS; t++) begin
            apb_write(8'(REG_W0 + 4 * t), 32'(row_w[r][t]), 1'b0);
            apb_write(8'(REG_P0 + 4 * t), 32'(row_p[r][t]), 1'b0);
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] rdata;
        load_row(r);
        apb_write(REG_CTRL, {30'd0, row_mode[r], 1'b1}, 1'b0);
        // The sticky done bit clears as soon as the start is taken.
        apb_read(REG_STATUS, rdata, 1'b0);
        check_value("status after start", rdata, 32'h1);
        wait_done();
        apb_read(REG_RESULT, rdata, 1'b0);
        check_value($sformatf("result row %0d", r), rdata, 32'(row_sum[r]));
        apb_read(REG_STATUS, rdata, 1'b0);
        check_value("status after done", rdata, 32'h2);
    endtask

    task automatic check_readback();
        logic [31:0] rdata;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            apb_write(8'(REG_W0 + 4 * t), 32'(8'ha5 ^ 8'(t)), 1'b0);
            apb_write(8'(REG_P0 + 4 * t), 32'(8'h3c + 8'(t)), 1'b0);
        end
        for (int t = 0; t < `CONV_TAPS; t++) begin
            apb_read(8'(REG_W0 + 4 * t), rdata, 1'b0);
            check_value($sformatf("weight %0d", t), rdata, 32'(8'ha5 ^ 8'(t)));
            apb_read(8'(REG_P0 + 4 * t), rdata, 1'b0);
            check_value($sformatf("pixel %0d", t), rdata, 32'(8'h3c + 8'(t)));
        end
        apb_write(REG_CTRL, 32'h2, 1'b0);
        apb_read(REG_CTRL, rdata, 1'b0);
        check_value("ctrl mode", rdata, 32'h2);
        apb_write(REG_CTRL, 32'h0, 1'b0);
    endtask

    task automatic check_error_response();
        logic [31:0] rdata;
        load_row(1);
        apb_read(8'h44, rdata, 1'b1);
        apb_write(REG_RESULT, 32'h1234, 1'b1);
        apb_write(REG_STATUS, 32'h0, 1'b1);
        apb_write(REG_CTRL, {30'd0, row_mode[1], 1'b1}, 1'b0);
        apb_write(REG_W0, 32'hee, 1'b1);
        apb_write(REG_CTRL, 32'h1, 1'b1);
        wait_done();
        apb_read(REG_RESULT, rdata, 1'b0);
        check_value("result after refused writes", rdata, 32'(row_sum[1]));
        apb_read(REG_W0, rdata, 1'b0);
        check_value("weight 0 after refused write", rdata, 32'(row_w[1][0]));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rdata;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        seed       = 32'h3c1f_5271;
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        apb_read(REG_STATUS, rdata, 1'b0);
        check_value("status after reset", rdata, 32'h0);
        apb_read(REG_RESULT, rdata, 1'b0);
        check_value("result after reset", rdata, 32'h0);
        check_readback();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        check_error_response();

        $display("All checks passed");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tb_conv_row_assert.sv ====
module tb_conv_row_assert (
    input logic clk,
    input logic arst_n,
    input logic pready,
    input logic start,
    input logic busy,
    input logic done
);

    // The slave never inserts wait states.
    pready_high: assert property (@(posedge clk) disable iff (!arst_n) pready)
        else $error("pready dropped low");

    done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else $error("done held high for more than one cycle");

    busy_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
        else $error("busy set right after reset");

    // Five taps, then one flush cycle, then the done pulse.
    start_to_done: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> ##7 (done && !busy))
        else $error("done not seen 7 cycles after start");

endmodule

bind conv_row_top tb_conv_row_assert u_assert (
    .clk    (clk),
    .arst_n (arst_n),
    .pready (pready),
    .start  (u_bus.start),
    .busy   (u_bus.busy),
    .done   (u_bus.done)
);

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

// ==== conv_row_top.sv ====
`include "conv_macros.svh"

module conv_row_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`CONV_AW-1:0] paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr
);

    mac_if u_bus ();

    // Host side register block.
    conv_apb_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (u_bus.regs)
    );

    // Row engine.
    conv_row_mac u_mac (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (u_bus.engine)
    );

endmodule

// ==== conv_apb_regs.sv ====
`include "conv_macros.svh"

module conv_apb_regs import conv_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`CONV_AW-1:0] paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    mac_if.regs                 bus
);

    logic [`CONV_TAPS-1:0][`CONV_DW-1:0] weights_q;
    logic [`CONV_TAPS-1:0][`CONV_DW-1:0] pixels_q;
    logic [`CONV_ACC_W-1:0]              result_q;
    logic                                exact_mode_q;
    logic                                start_q;
    logic                                done_sticky;
    logic [`CONV_TAPS-1:0]               w_hit;
    logic [`CONV_TAPS-1:0]               p_hit;
    logic                                ctrl_hit;
    logic                                stat_hit;
    logic                                res_hit;
    logic                                mapped;
    logic                                engine_busy;
    logic                                access;
    logic                                err;
    logic                                wr_ok;
    logic                                start_ok;

    assign access      = psel & penable;
    assign engine_busy = bus.busy | start_q;
    assign pready      = 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode and read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ctrl_hit = 1'b0;
        stat_hit = 1'b0;
        res_hit  = 1'b0;
        w_hit    = '0;
        p_hit    = '0;
        case (paddr)
            REG_CTRL:   ctrl_hit = 1'b1;
            REG_STATUS: stat_hit = 1'b1;
            REG_RESULT: res_hit  = 1'b1;
            REG_W0:     w_hit[0] = 1'b1;
            REG_W1:     w_hit[1] = 1'b1;
            REG_W2:     w_hit[2] = 1'b1;
            REG_W3:     w_hit[3] = 1'b1;
            REG_W4:     w_hit[4] = 1'b1;
            REG_P0:     p_hit[0] = 1'b1;
            REG_P1:     p_hit[1] = 1'b1;
            REG_P2:     p_hit[2] = 1'b1;
            REG_P3:     p_hit[3] = 1'b1;
            REG_P4:     p_hit[4] = 1'b1;
            default:    ;
        endcase
        mapped = ctrl_hit | stat_hit | res_hit | (|w_hit) | (|p_hit);

        prdata = '0;
        if (ctrl_hit) begin
            prdata[1] = exact_mode_q;
        end
        if (stat_hit) begin
            prdata[1:0] = {done_sticky, engine_busy};
        end
        if (res_hit) begin
            prdata[`CONV_ACC_W-1:0] = result_q;
        end
        for (int i = 0; i < `CONV_TAPS; i++) begin
            if (w_hit[i]) begin
                prdata[`CONV_DW-1:0] = weights_q[i];
            end
            if (p_hit[i]) begin
                prdata[`CONV_DW-1:0] = pixels_q[i];
            end
        end
    end

    // Status and result are read only; operands and control lock while busy.
    assign err = ~mapped
               | (pwrite & (stat_hit | res_hit))
               | (pwrite & engine_busy & (ctrl_hit | (|w_hit) | (|p_hit)));

    assign pslverr  = access & err;
    assign wr_ok    = access & pwrite & ~err;
    assign start_ok = wr_ok & ctrl_hit & pwdata[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exact_mode_q <= 1'b0;
            start_q      <= 1'b0;
            done_sticky  <= 1'b0;
            result_q     <= '0;
        end else begin
            start_q <= start_ok;
            if (wr_ok && ctrl_hit) begin
                exact_mode_q <= pwdata[1];
            end
            if (bus.done) begin
                done_sticky <= 1'b1;
                result_q    <= bus.result;
            end else if (start_ok) begin
                done_sticky <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CONV_TAPS; i++) begin
            if (wr_ok && w_hit[i]) begin
                weights_q[i] <= pwdata[`CONV_DW-1:0];
            end
            if (wr_ok && p_hit[i]) begin
                pixels_q[i] <= pwdata[`CONV_DW-1:0];
            end
        end
    end

    assign bus.weights    = weights_q;
    assign bus.pixels     = pixels_q;
    assign bus.exact_mode = exact_mode_q;
    assign bus.start      = start_q;

endmodule

// ==== conv_row_mac.sv ====
`include "conv_macros.svh"

module conv_row_mac import conv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    mac_if.engine bus
);

    mac_state_e             state;
    logic [2:0]             tap_idx;
    logic                   mode_q;
    logic                   done_q;
    logic                   acc_en;
    logic [`CONV_DW-1:0]    cur_w;
    logic [`CONV_DW-1:0]    cur_p;
    logic [`CONV_PW-1:0]    approx_z;
    logic [`CONV_PW-1:0]    exact_z;
    logic [`CONV_PW-1:0]    prod_q;
    logic [`CONV_ACC_W-1:0] prod_ext;
    logic [`CONV_ACC_W-1:0] acc_q;

    assign cur_w = bus.weights[tap_idx];
    assign cur_p = bus.pixels[tap_idx];

    // Weight drives x, so weights with bits 0 to 5 clear multiply exactly.
    approx_mult8 u_mult (
        .x (cur_w),
        .y (cur_p),
        .z (approx_z)
    );

    assign exact_z  = cur_w * cur_p;
    assign prod_ext = {{(`CONV_ACC_W - `CONV_PW){1'b0}}, prod_q};

    // The product register lags the tap index by one cycle, so the first
    // RUN cycle has nothing to add and FLUSH adds the last tap.
    assign acc_en = ((state == ST_RUN) && (tap_idx != 3'd0)) || (state == ST_FLUSH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer and accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            tap_idx <= '0;
            mode_q  <= 1'b0;
            done_q  <= 1'b0;
            acc_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (acc_en) begin
                acc_q <= acc_q + prod_ext;
            end
            case (state)
                ST_IDLE: begin
                    if (bus.start) begin
                        state   <= ST_RUN;
                        tap_idx <= '0;
                        mode_q  <= bus.exact_mode;
                        acc_q   <= '0;
                    end
                end
                ST_RUN: begin
                    if (tap_idx == 3'(`CONV_TAPS - 1)) begin
                        state <= ST_FLUSH;
                    end else begin
                        tap_idx <= tap_idx + 3'd1;
                    end
                end
                ST_FLUSH: begin
                    done_q <= 1'b1;
                    state  <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_RUN) begin
            prod_q <= mode_q ? exact_z : approx_z;
        end
    end

    assign bus.busy   = (state != ST_IDLE);
    assign bus.done   = done_q;
    assign bus.result = acc_q;

endmodule

// ==== approx_mult8.sv ====
`include "conv_macros.svh"

module approx_mult8 (
    input  logic [`CONV_DW-1:0] x,
    input  logic [`CONV_DW-1:0] y,
    output logic [`CONV_PW-1:0] z
);

    logic [7:0][7:0]  pp;
    logic [6:0][12:0] corr;

    // Row i is y gated by multiplier bit i, weighted by 2**i.
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Correction words from rows 0 to 5, MSB first.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign corr[0] = {pp[4][7] & pp[5][6], pp[4][7] ^ pp[5][6], pp[3][7],
                      pp[2][7] | pp[3][6], pp[1][7], pp[0][7] ^ pp[1][6],
                      pp[2][3] & pp[3][2], pp[0][4] ^ pp[1][3], 1'b0,
                      pp[0][2] & pp[1][1], pp[2][0], 2'b00};

    assign corr[1] = {pp[5][7], 1'b0, pp[4][5] & pp[5][4],
                      pp[4][5] ^ pp[5][4], pp[2][5] | pp[3][4], 2'b00,
                      pp[0][5] | pp[1][4], 1'b0,
                      pp[2][1] | pp[3][0], 3'b000};

    assign corr[2] = {2'b00, pp[4][6] & pp[5][5], 1'b0,
                      pp[2][6] & pp[3][5], 2'b00,
                      pp[2][2] ^ pp[3][1], 5'b00000};

    assign corr[3] = {2'b00, pp[4][6] | pp[5][5], 1'b0,
                      pp[2][6] | pp[3][5], 8'h00};

    // The last three words each hold a single bit at weight 2**8.
    assign corr[4] = {4'h0, pp[4][3] | pp[5][2], 8'h00};
    assign corr[5] = {4'h0, pp[4][4] & pp[5][3], 8'h00};
    assign corr[6] = {4'h0, pp[4][4] | pp[5][3], 8'h00};

    // Rows 6 and 7 go in exactly at their true weights.
    always_comb begin
        z = {2'b00, pp[6], 6'b000000} + {1'b0, pp[7], 7'b0000000};
        for (int k = 0; k < 7; k++) begin
            z = z + {3'b000, corr[k]};
        end
    end

endmodule

// ==== mac_if.sv ====
`include "conv_macros.svh"

interface mac_if;

    logic [`CONV_TAPS-1:0][`CONV_DW-1:0] weights;
    logic [`CONV_TAPS-1:0][`CONV_DW-1:0] pixels;
    logic                                exact_mode;
    logic                                start;

    logic                                busy;
    logic                                done;
    logic [`CONV_ACC_W-1:0]              result;

    modport regs (
        output weights,
        output pixels,
        output exact_mode,
        output start,
        input  busy,
        input  done,
        input  result
    );

    modport engine (
        input  weights,
        input  pixels,
        input  exact_mode,
        input  start,
        output busy,
        output done,
        output result
    );

endinterface

// ==== conv_pkg.sv ====
`include "conv_macros.svh"

package conv_pkg;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_FLUSH = 2'd2
    } mac_state_e;

    // Byte offsets of the host-visible registers.
    typedef enum logic [`CONV_AW-1:0] {
        REG_CTRL   = 8'h00,
        REG_STATUS = 8'h04,
        REG_RESULT = 8'h08,
        REG_W0     = 8'h10,
        REG_W1     = 8'h14,
        REG_W2     = 8'h18,
        REG_W3     = 8'h1c,
        REG_W4     = 8'h20,
        REG_P0     = 8'h30,
        REG_P1     = 8'h34,
        REG_P2     = 8'h38,
        REG_P3     = 8'h3c,
        REG_P4     = 8'h40
    } reg_addr_e;

endpackage

// ==== conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Taps in one kernel row.
`define CONV_TAPS 5

// Operand width for weights and pixels.
`define CONV_DW 8

// Full product width of one 8x8 multiply.
`define CONV_PW 16

// Five maximal products fit in 19 bits.
`define CONV_ACC_W 19

// APB address width.
`define CONV_AW 8

`endif
